// File: hw/m6502_pkg.sv
/*
 * Reduced MOS 6502 core definitions
 * Bus widths and types, the decoded operation, addressing mode,
 * register select, ALU function and sequencer state enums, and the
 * bit positions of N, V, Z and C in the status byte.
 */
`default_nettype none

package m6502_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;

   typedef enum logic [5:0] {
      OP_NOP,
      OP_LDA, OP_LDX, OP_LDY,
      OP_STA, OP_STX, OP_STY,
      OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR, OP_CMP,
      OP_INX, OP_INY, OP_DEX, OP_DEY,
      OP_TAX, OP_TAY, OP_TXA, OP_TYA,
      OP_CLC, OP_SEC, OP_CLV,
      OP_BRANCH, OP_JMP
   } op_e;

   typedef enum logic [1:0] {
      MODE_IMPL,
      MODE_IMM,
      MODE_ZP,
      MODE_ABS
   } mode_e;

   typedef enum logic [1:0] {
      REG_NONE,
      REG_A,
      REG_X,
      REG_Y
   } reg_sel_e;

   typedef enum logic [2:0] {
      ALU_PASS,
      ALU_ADC,   // Also SBC with the operand inverted
      ALU_AND,
      ALU_OR,
      ALU_EOR,
      ALU_CMP,
      ALU_INC,
      ALU_DEC
   } alu_op_e;

   typedef enum logic [2:0] {
      ST_RESET_LO,
      ST_RESET_HI,
      ST_FETCH,
      ST_DECODE,
      ST_OPER_LO,
      ST_OPER_HI,
      ST_MEM,
      ST_EXEC
   } state_e;

   localparam int FLAG_N = 7;
   localparam int FLAG_V = 6;
   localparam int FLAG_Z = 1;
   localparam int FLAG_C = 0;

endpackage

`default_nettype wire

// File: hw/m6502_decode.sv
/*
 * 6502 opcode decoder
 * Splits the opcode into aaa/bbb/cc and maps the supported
 * instructions to operation, addressing mode and registers.
 * Anything else decodes as a one-byte NOP.
 */
`default_nettype none

module m6502_decode (
   input  wire m6502_pkg::data_t  opcode_i,
   output m6502_pkg::op_e         op_o,
   output m6502_pkg::mode_e       mode_o,
   output m6502_pkg::reg_sel_e    src_o,
   output m6502_pkg::reg_sel_e    dst_o
);

   logic [2:0]       aaa;
   logic [2:0]       bbb;
   logic [1:0]       cc;
   m6502_pkg::mode_e mem_mode;
   logic             mem_ok;

   assign aaa    = opcode_i[7:5];
   assign bbb    = opcode_i[4:2];
   assign cc     = opcode_i[1:0];
   assign mem_ok = (mem_mode != m6502_pkg::MODE_IMPL);

   // Immediate sits at bbb=2 in group 01 and at bbb=0 in the others
   always_comb
   begin
      mem_mode = m6502_pkg::MODE_IMPL;
      case (bbb)
         3'd0: if (cc != 2'b01) mem_mode = m6502_pkg::MODE_IMM;
         3'd1: mem_mode = m6502_pkg::MODE_ZP;
         3'd2: if (cc == 2'b01) mem_mode = m6502_pkg::MODE_IMM;
         3'd3: mem_mode = m6502_pkg::MODE_ABS;
         default: ;
      endcase
   end

   always_comb
   begin
      op_o   = m6502_pkg::OP_NOP;
      mode_o = m6502_pkg::MODE_IMPL;
      src_o  = m6502_pkg::REG_NONE;
      dst_o  = m6502_pkg::REG_NONE;
      case (cc)
         2'b01:
            if (mem_ok && !(aaa == 3'b100 && mem_mode == m6502_pkg::MODE_IMM))
            begin
               mode_o = mem_mode;
               src_o  = m6502_pkg::REG_A;
               dst_o  = m6502_pkg::REG_A;
               case (aaa)
                  3'b000: op_o = m6502_pkg::OP_ORA;
                  3'b001: op_o = m6502_pkg::OP_AND;
                  3'b010: op_o = m6502_pkg::OP_EOR;
                  3'b011: op_o = m6502_pkg::OP_ADC;
                  3'b101: op_o = m6502_pkg::OP_LDA;
                  3'b111: op_o = m6502_pkg::OP_SBC;
                  3'b100:
                  begin
                     op_o  = m6502_pkg::OP_STA;
                     dst_o = m6502_pkg::REG_NONE;
                  end
                  default:
                  begin
                     op_o  = m6502_pkg::OP_CMP;   // Flags only
                     dst_o = m6502_pkg::REG_NONE;
                  end
               endcase
            end
         2'b10:
            if (bbb == 3'd2)
            begin
               case (aaa)
                  3'b100:
                  begin
                     op_o  = m6502_pkg::OP_TXA;
                     src_o = m6502_pkg::REG_X;
                     dst_o = m6502_pkg::REG_A;
                  end
                  3'b101:
                  begin
                     op_o  = m6502_pkg::OP_TAX;
                     src_o = m6502_pkg::REG_A;
                     dst_o = m6502_pkg::REG_X;
                  end
                  3'b110:
                  begin
                     op_o  = m6502_pkg::OP_DEX;
                     src_o = m6502_pkg::REG_X;
                     dst_o = m6502_pkg::REG_X;
                  end
                  default: ;
               endcase
            end
            else if (mem_ok && aaa == 3'b101)
            begin
               op_o   = m6502_pkg::OP_LDX;
               mode_o = mem_mode;
               dst_o  = m6502_pkg::REG_X;
            end
            else if (mem_ok && aaa == 3'b100 && mem_mode != m6502_pkg::MODE_IMM)
            begin
               op_o   = m6502_pkg::OP_STX;
               mode_o = mem_mode;
               src_o  = m6502_pkg::REG_X;
            end
         2'b00:
            if (bbb == 3'd4)
            begin
               op_o   = m6502_pkg::OP_BRANCH;   // Condition is in aaa
               mode_o = m6502_pkg::MODE_IMM;
            end
            else if (bbb == 3'd6)
            begin
               case (aaa)
                  3'b000: op_o = m6502_pkg::OP_CLC;
                  3'b001: op_o = m6502_pkg::OP_SEC;
                  3'b101: op_o = m6502_pkg::OP_CLV;
                  3'b100:
                  begin
                     op_o  = m6502_pkg::OP_TYA;
                     src_o = m6502_pkg::REG_Y;
                     dst_o = m6502_pkg::REG_A;
                  end
                  default: ;
               endcase
            end
            else if (bbb == 3'd2)
            begin
               case (aaa)
                  3'b100: op_o = m6502_pkg::OP_DEY;
                  3'b101: op_o = m6502_pkg::OP_TAY;
                  3'b110: op_o = m6502_pkg::OP_INY;
                  3'b111: op_o = m6502_pkg::OP_INX;
                  default: ;
               endcase
               src_o = (aaa == 3'b101) ? m6502_pkg::REG_A
                     : (aaa == 3'b111) ? m6502_pkg::REG_X : m6502_pkg::REG_Y;
               dst_o = (aaa == 3'b111) ? m6502_pkg::REG_X : m6502_pkg::REG_Y;
               if (!aaa[2])
               begin
                  src_o = m6502_pkg::REG_NONE;   // Stack ops, not kept
                  dst_o = m6502_pkg::REG_NONE;
               end
            end
            else if (aaa == 3'b010 && bbb == 3'd3)
            begin
               op_o   = m6502_pkg::OP_JMP;
               mode_o = m6502_pkg::MODE_ABS;
            end
            else if (mem_ok && aaa == 3'b101)
            begin
               op_o   = m6502_pkg::OP_LDY;
               mode_o = mem_mode;
               dst_o  = m6502_pkg::REG_Y;
            end
            else if (mem_ok && aaa == 3'b100 && mem_mode != m6502_pkg::MODE_IMM)
            begin
               op_o   = m6502_pkg::OP_STY;
               mode_o = mem_mode;
               src_o  = m6502_pkg::REG_Y;
            end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/m6502_alu.sv
/*
 * 6502 ALU and status flags
 * Combinational 8-bit result from register and operand, the N/V/Z/C
 * register updated on the flag strobe, and the branch test.
 */
`default_nettype none

module m6502_alu (
   input  wire                    clk,
   input  wire                    reset_n,
   input  wire m6502_pkg::op_e    op_i,
   input  wire [2:0]              cond_i,
   input  wire m6502_pkg::data_t  src_val_i,
   input  wire m6502_pkg::data_t  operand_i,
   input  wire                    flag_load_i,
   output m6502_pkg::data_t       result_o,
   output logic                   take_branch_o,
   output m6502_pkg::data_t       flags_o
);

   m6502_pkg::alu_op_e alu_op;
   logic               is_load;
   m6502_pkg::data_t   add_b;
   logic               add_cin;
   logic [8:0]         sum;
   logic               ovf;
   logic               flag_n;
   logic               flag_v;
   logic               flag_z;
   logic               flag_c;

   always_comb
   begin
      is_load = 1'b0;
      case (op_i)
         m6502_pkg::OP_LDA, m6502_pkg::OP_LDX, m6502_pkg::OP_LDY:
         begin
            alu_op  = m6502_pkg::ALU_PASS;
            is_load = 1'b1;
         end
         m6502_pkg::OP_ADC, m6502_pkg::OP_SBC: alu_op = m6502_pkg::ALU_ADC;
         m6502_pkg::OP_AND: alu_op = m6502_pkg::ALU_AND;
         m6502_pkg::OP_ORA: alu_op = m6502_pkg::ALU_OR;
         m6502_pkg::OP_EOR: alu_op = m6502_pkg::ALU_EOR;
         m6502_pkg::OP_CMP: alu_op = m6502_pkg::ALU_CMP;
         m6502_pkg::OP_INX, m6502_pkg::OP_INY: alu_op = m6502_pkg::ALU_INC;
         m6502_pkg::OP_DEX, m6502_pkg::OP_DEY: alu_op = m6502_pkg::ALU_DEC;
         default: alu_op = m6502_pkg::ALU_PASS;   // Transfers
      endcase
   end

   // Subtraction as A + ~M + carry in
   assign add_b   = (op_i == m6502_pkg::OP_SBC || op_i == m6502_pkg::OP_CMP) ? ~operand_i
                                                                             : operand_i;
   assign add_cin = (alu_op == m6502_pkg::ALU_CMP) ? 1'b1 : flag_c;
   assign sum     = {1'b0, src_val_i} + {1'b0, add_b} + {8'h00, add_cin};
   assign ovf     = (src_val_i[7] == add_b[7]) && (sum[7] != src_val_i[7]);

   always_comb
   begin
      case (alu_op)
         m6502_pkg::ALU_ADC, m6502_pkg::ALU_CMP: result_o = sum[7:0];
         m6502_pkg::ALU_AND: result_o = src_val_i & operand_i;
         m6502_pkg::ALU_OR:  result_o = src_val_i | operand_i;
         m6502_pkg::ALU_EOR: result_o = src_val_i ^ operand_i;
         m6502_pkg::ALU_INC: result_o = src_val_i + 8'd1;
         m6502_pkg::ALU_DEC: result_o = src_val_i - 8'd1;
         default:            result_o = is_load ? operand_i : src_val_i;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         flag_n <= 1'b0;
         flag_v <= 1'b0;
         flag_z <= 1'b0;
         flag_c <= 1'b0;
      end
      else if (flag_load_i)
      begin
         case (op_i)
            m6502_pkg::OP_CLC: flag_c <= 1'b0;
            m6502_pkg::OP_SEC: flag_c <= 1'b1;
            m6502_pkg::OP_CLV: flag_v <= 1'b0;
            m6502_pkg::OP_NOP, m6502_pkg::OP_STA, m6502_pkg::OP_STX, m6502_pkg::OP_STY,
            m6502_pkg::OP_BRANCH, m6502_pkg::OP_JMP: ;
            default:
            begin
               flag_n <= result_o[7];
               flag_z <= (result_o == 8'h00);
               if (alu_op == m6502_pkg::ALU_ADC || alu_op == m6502_pkg::ALU_CMP)
                  flag_c <= sum[8];   // For CMP no borrow means reg >= operand
               if (alu_op == m6502_pkg::ALU_ADC)
                  flag_v <= ovf;
            end
         endcase
      end
   end

   always_comb
   begin
      flags_o                    = '0;
      flags_o[m6502_pkg::FLAG_N] = flag_n;
      flags_o[m6502_pkg::FLAG_V] = flag_v;
      flags_o[m6502_pkg::FLAG_Z] = flag_z;
      flags_o[m6502_pkg::FLAG_C] = flag_c;
   end

   // cond_i[2:1] picks N, V, C or Z and cond_i[0] the wanted value
   always_comb
   begin
      case (cond_i[2:1])
         2'b00:   take_branch_o = (flag_n == cond_i[0]);
         2'b01:   take_branch_o = (flag_v == cond_i[0]);
         2'b10:   take_branch_o = (flag_c == cond_i[0]);
         default: take_branch_o = (flag_z == cond_i[0]);
      endcase
   end

   a_flags_hold: assert property (@(posedge clk) disable iff (!reset_n)
      !flag_load_i |=> $stable(flags_o));

endmodule

`default_nettype wire

// File: hw/m6502_regs.sv
/*
 * 6502 register file
 * A, X and Y with writeback to the decoded target and the
 * source register read out for the ALU and for stores.
 */
`default_nettype none

module m6502_regs (
   input  wire                      clk,
   input  wire                      reset_n,
   input  wire                      reg_load_i,
   input  wire m6502_pkg::reg_sel_e dst_i,
   input  wire m6502_pkg::reg_sel_e src_i,
   input  wire m6502_pkg::data_t    result_i,
   output m6502_pkg::data_t         src_val_o,
   output m6502_pkg::data_t         store_data_o
);

   m6502_pkg::data_t reg_a;
   m6502_pkg::data_t reg_x;
   m6502_pkg::data_t reg_y;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         reg_a <= '0;
         reg_x <= '0;
         reg_y <= '0;
      end
      else if (reg_load_i)
      begin
         case (dst_i)
            m6502_pkg::REG_A: reg_a <= result_i;
            m6502_pkg::REG_X: reg_x <= result_i;
            m6502_pkg::REG_Y: reg_y <= result_i;
            default: ;   // CMP, stores and flag ops
         endcase
      end
   end

   always_comb
   begin
      case (src_i)
         m6502_pkg::REG_A: src_val_o = reg_a;
         m6502_pkg::REG_X: src_val_o = reg_x;
         m6502_pkg::REG_Y: src_val_o = reg_y;
         default:          src_val_o = '0;
      endcase
   end

   assign store_data_o = src_val_o;

endmodule

`default_nettype wire

// File: hw/m6502_control.sv
/*
 * 6502 bus sequencer
 * Reads the reset vector, then fetches each instruction with its
 * operand bytes and data access, one bus request at a time held until
 * ready. Owns the PC and raises the execute strobes.
 */
`default_nettype none

module m6502_control #(
   parameter m6502_pkg::addr_t RESET_VECTOR = 16'hFFFC
) (
   input  wire                    clk,
   input  wire                    reset_n,
   input  wire m6502_pkg::data_t  rd_data_i,
   input  wire                    ready_i,
   input  wire m6502_pkg::op_e    op_i,
   input  wire m6502_pkg::mode_e  mode_i,
   input  wire                    take_branch_i,
   input  wire m6502_pkg::data_t  store_data_i,
   output m6502_pkg::addr_t       addr_o,
   output m6502_pkg::data_t       wr_data_o,
   output logic                   wr_en_o,
   output logic                   rd_req_o,
   output m6502_pkg::data_t       opcode_o,
   output m6502_pkg::data_t       operand_o,
   output logic                   reg_load_o,
   output logic                   flag_load_o
);

   m6502_pkg::state_e state;
   m6502_pkg::addr_t  pc;
   m6502_pkg::addr_t  pc_next;   // PC of the following instruction
   m6502_pkg::addr_t  pc_new;
   m6502_pkg::data_t  addr_lo;
   m6502_pkg::data_t  addr_hi;
   logic              is_store;

   assign is_store = (op_i == m6502_pkg::OP_STA) || (op_i == m6502_pkg::OP_STX)
                   || (op_i == m6502_pkg::OP_STY);

   always_comb
   begin
      case (mode_i)
         m6502_pkg::MODE_IMPL: pc_next = pc + 16'd1;
         m6502_pkg::MODE_ABS:  pc_next = pc + 16'd3;
         default:              pc_next = pc + 16'd2;
      endcase
      if (op_i == m6502_pkg::OP_JMP)
         pc_new = {addr_hi, addr_lo};
      else if (op_i == m6502_pkg::OP_BRANCH && take_branch_i)
         pc_new = pc_next + {{8{operand_o[7]}}, operand_o};   // Signed offset
      else
         pc_new = pc_next;
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state    <= m6502_pkg::ST_RESET_LO;
         rd_req_o <= 1'b0;
         wr_en_o  <= 1'b0;
      end
      else
      begin
         case (state)
            m6502_pkg::ST_RESET_LO:
               if (!rd_req_o)
               begin
                  rd_req_o <= 1'b1;
                  addr_o   <= RESET_VECTOR;
               end
               else if (ready_i)
               begin
                  addr_lo <= rd_data_i;
                  addr_o  <= RESET_VECTOR + 16'd1;
                  state   <= m6502_pkg::ST_RESET_HI;
               end
            m6502_pkg::ST_RESET_HI:
               if (ready_i)
               begin
                  pc     <= {rd_data_i, addr_lo};
                  addr_o <= {rd_data_i, addr_lo};   // First fetch follows at once
                  state  <= m6502_pkg::ST_FETCH;
               end
            m6502_pkg::ST_FETCH:
               if (ready_i)
               begin
                  opcode_o <= rd_data_i;
                  rd_req_o <= 1'b0;
                  state    <= m6502_pkg::ST_DECODE;
               end
            m6502_pkg::ST_DECODE:
               if (mode_i == m6502_pkg::MODE_IMPL)
                  state <= m6502_pkg::ST_EXEC;
               else
               begin
                  rd_req_o <= 1'b1;
                  addr_o   <= pc + 16'd1;
                  state    <= m6502_pkg::ST_OPER_LO;
               end
            m6502_pkg::ST_OPER_LO:
               if (ready_i)
               begin
                  operand_o <= rd_data_i;
                  addr_lo   <= rd_data_i;
                  case (mode_i)
                     m6502_pkg::MODE_ZP:
                     begin
                        addr_o   <= {8'h00, rd_data_i};
                        rd_req_o <= !is_store;
                        wr_en_o  <= is_store;
                        state    <= m6502_pkg::ST_MEM;
                     end
                     m6502_pkg::MODE_ABS:
                     begin
                        addr_o <= pc + 16'd2;
                        state  <= m6502_pkg::ST_OPER_HI;
                     end
                     default:
                     begin
                        rd_req_o <= 1'b0;
                        state    <= m6502_pkg::ST_EXEC;
                     end
                  endcase
               end
            m6502_pkg::ST_OPER_HI:
               if (ready_i)
               begin
                  addr_hi <= rd_data_i;
                  if (op_i == m6502_pkg::OP_JMP)
                  begin
                     rd_req_o <= 1'b0;
                     state    <= m6502_pkg::ST_EXEC;
                  end
                  else
                  begin
                     addr_o   <= {rd_data_i, addr_lo};
                     rd_req_o <= !is_store;
                     wr_en_o  <= is_store;
                     state    <= m6502_pkg::ST_MEM;
                  end
               end
            m6502_pkg::ST_MEM:
               if (ready_i)
               begin
                  if (rd_req_o)
                     operand_o <= rd_data_i;   // Data byte replaces the address byte
                  rd_req_o <= 1'b0;
                  wr_en_o  <= 1'b0;
                  state    <= m6502_pkg::ST_EXEC;
               end
            default:
            begin
               pc       <= pc_new;
               addr_o   <= pc_new;
               rd_req_o <= 1'b1;
               state    <= m6502_pkg::ST_FETCH;
            end
         endcase
      end
   end

   assign wr_data_o   = store_data_i;   // Register is stable for the whole store
   assign reg_load_o  = (state == m6502_pkg::ST_EXEC);
   assign flag_load_o = (state == m6502_pkg::ST_EXEC);

   a_one_request: assert property (@(posedge clk) disable iff (!reset_n)
      !(rd_req_o && wr_en_o));

   a_request_held: assert property (@(posedge clk) disable iff (!reset_n)
      (rd_req_o || wr_en_o) && !ready_i |=> $stable(addr_o) && (rd_req_o || wr_en_o));

endmodule

`default_nettype wire

// File: hw/m6502_cpu.sv
/*
 * Reduced MOS 6502 core
 * Sequencer, decoder, ALU and registers on one 8-bit
 * request/ready memory bus.
 */
`default_nettype none

module m6502_cpu #(
   parameter m6502_pkg::addr_t RESET_VECTOR = 16'hFFFC
) (
   input  wire                    clk,
   input  wire                    reset_n,
   output m6502_pkg::addr_t       addr_o,
   input  wire m6502_pkg::data_t  rd_data_i,
   output m6502_pkg::data_t       wr_data_o,
   output logic                   wr_en_o,
   output logic                   rd_req_o,
   input  wire                    ready_i
);

   m6502_pkg::data_t    opcode;
   m6502_pkg::data_t    operand;
   m6502_pkg::op_e      op;
   m6502_pkg::mode_e    mode;
   m6502_pkg::reg_sel_e src;
   m6502_pkg::reg_sel_e dst;
   m6502_pkg::data_t    src_val;
   m6502_pkg::data_t    store_data;
   m6502_pkg::data_t    result;
   logic                take_branch;
   logic                reg_load;
   logic                flag_load;

   m6502_control #(
      .RESET_VECTOR (RESET_VECTOR)
   ) control_i (
      .clk           (clk),
      .reset_n       (reset_n),
      .rd_data_i     (rd_data_i),
      .ready_i       (ready_i),
      .op_i          (op),
      .mode_i        (mode),
      .take_branch_i (take_branch),
      .store_data_i  (store_data),
      .addr_o        (addr_o),
      .wr_data_o     (wr_data_o),
      .wr_en_o       (wr_en_o),
      .rd_req_o      (rd_req_o),
      .opcode_o      (opcode),
      .operand_o     (operand),
      .reg_load_o    (reg_load),
      .flag_load_o   (flag_load)
   );

   m6502_decode decode_i (
      .opcode_i (opcode),
      .op_o     (op),
      .mode_o   (mode),
      .src_o    (src),
      .dst_o    (dst)
   );

   m6502_alu alu_i (
      .clk           (clk),
      .reset_n       (reset_n),
      .op_i          (op),
      .cond_i        (opcode[7:5]),   // Branch condition field
      .src_val_i     (src_val),
      .operand_i     (operand),
      .flag_load_i   (flag_load),
      .result_o      (result),
      .take_branch_o (take_branch),
      .flags_o       ()               // Status byte, visible in the hierarchy
   );

   m6502_regs regs_i (
      .clk          (clk),
      .reset_n      (reset_n),
      .reg_load_i   (reg_load),
      .dst_i        (dst),
      .src_i        (src),
      .result_i     (result),
      .src_val_o    (src_val),
      .store_data_o (store_data)
   );

endmodule

`default_nettype wire

// File: bench/m6502_mem.sv
/*
 * Byte memory model for the 6502 bench
 * 64K bytes on the request/ready bus. Ready and read data are driven
 * 1 ns after the rising edge, with optional random stalls. The first
 * write after reset is captured for the checker.
 */
`default_nettype none

module m6502_mem (
   input  wire         clk,
   input  wire         reset_n,
   input  wire         stall_en_i,
   input  wire  [15:0] addr_i,
   input  wire  [7:0]  wr_data_i,
   input  wire         wr_en_i,
   input  wire         rd_req_i,
   output logic [7:0]  rd_data_o,
   output logic        ready_o,
   output logic        written_o,
   output logic [15:0] wr_addr_o,
   output logic [7:0]  wr_value_o
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [7:0] mem [0:65535];
   integer     seed;
   logic       stall;

   initial
   begin
      seed       = 32'h67b9;
      stall      = 1'b0;
      rd_data_o  = 8'h00;
      ready_o    = 1'b0;
      written_o  = 1'b0;
      wr_addr_o  = 16'h0000;
      wr_value_o = 8'h00;
   end

   always @(posedge clk)
   begin
      if (wr_en_i && ready_o)
      begin
         mem[addr_i] = wr_data_i;
         if (!written_o)
         begin
            written_o  = 1'b1;   // Keep only the first write
            wr_addr_o  = addr_i;
            wr_value_o = wr_data_i;
         end
      end
      if (!reset_n)
         written_o = 1'b0;
      #1;
      stall     = stall_en_i && ($random(seed) & 1);   // About half the cycles
      ready_o   = (rd_req_i || wr_en_i) && !stall;
      rd_data_o = mem[addr_i];
   end

endmodule

`default_nettype wire

// File: bench/m6502_tb.sv
/*
 * Testbench for the reduced 6502 core
 * Runs a table of short programs from 0x0200, each ending in a store,
 * and checks the first write on the bus. The table runs once with a
 * ready memory and once with random stalls.
 */
`default_nettype none

module m6502_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_TESTS   = 26;
   localparam int RUNS        = 2 * NUM_TESTS;
   localparam int CYCLE_LIMIT = RUNS * 200;
   localparam logic [15:0] PROG_BASE = 16'h0200;
   localparam logic [15:0] VECTOR    = 16'hFFFC;

   logic              clk;
   logic              reset_n;
   logic              stall_en;
   m6502_pkg::addr_t  bus_addr;
   m6502_pkg::data_t  rd_data;
   m6502_pkg::data_t  wr_data;
   logic              wr_en;
   logic              rd_req;
   logic              ready;
   logic              written;
   logic [15:0]       wr_addr;
   logic [7:0]        wr_value;

   logic [127:0] code_tab  [NUM_TESTS];   // Program bytes, first byte leftmost
   logic [7:0]   zp_tab    [NUM_TESTS];
   logic [15:0]  addr_tab  [NUM_TESTS];
   logic [7:0]   value_tab [NUM_TESTS];
   int           entries;

   m6502_cpu #(
      .RESET_VECTOR (VECTOR)
   ) dut_i (
      .clk       (clk),
      .reset_n   (reset_n),
      .addr_o    (bus_addr),
      .rd_data_i (rd_data),
      .wr_data_o (wr_data),
      .wr_en_o   (wr_en),
      .rd_req_o  (rd_req),
      .ready_i   (ready)
   );

   m6502_mem mem_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .stall_en_i (stall_en),
      .addr_i     (bus_addr),
      .wr_data_i  (wr_data),
      .wr_en_i    (wr_en),
      .rd_req_i   (rd_req),
      .rd_data_o  (rd_data),
      .ready_o    (ready),
      .written_o  (written),
      .wr_addr_o  (wr_addr),
      .wr_value_o (wr_value)
   );

   initial
      clk = 1'b0;

   always #10 clk = ~clk;

   task automatic add_test(input logic [127:0] code, input logic [7:0] zp,
                           input logic [15:0] addr, input logic [7:0] value);
      code_tab[entries]  = code;
      zp_tab[entries]    = zp;
      addr_tab[entries]  = addr;
      value_tab[entries] = value;
      entries++;
   endtask

   task automatic build_table();
      entries = 0;
      add_test(128'hA9_42_8D_00_03, 8'h00, 16'h0300, 8'h42);                // LDA #, STA abs
      add_test(128'hA6_10_8E_01_03, 8'h9C, 16'h0301, 8'h9C);                // LDX zp, STX abs
      add_test(128'hA0_37_84_20, 8'h00, 16'h0020, 8'h37);                   // LDY #, STY zp
      add_test(128'hAD_10_00_8D_02_03, 8'h5A, 16'h0302, 8'h5A);             // LDA abs
      add_test(128'h38_18_A9_25_65_10_8D_03_03, 8'h13, 16'h0303, 8'h38);    // CLC ADC
      add_test(128'h38_A9_50_E5_10_8D_03_03, 8'h20, 16'h0303, 8'h30);       // SEC SBC
      add_test(128'h18_A9_F0_65_10_B0_03_8E_04_03_8D_04_03, 8'h20, 16'h0304, 8'h10);  // BCS
      add_test(128'h18_A9_70_65_10_70_03_8E_04_03_8D_04_03, 8'h20, 16'h0304, 8'h90);  // BVS
      add_test(128'h38_A9_10_E5_10_90_03_8E_04_03_8D_04_03, 8'h20, 16'h0304, 8'hF0);  // BCC
      add_test(128'h18_A9_70_65_10_50_03_8E_04_03_8D_04_03, 8'hF0, 16'h0304, 8'h60);  // BVC
      add_test(128'hA9_F0_29_3C_8D_05_03, 8'h00, 16'h0305, 8'h30);          // AND
      add_test(128'hA9_0F_09_30_8D_05_03, 8'h00, 16'h0305, 8'h3F);          // ORA
      add_test(128'hA9_FF_49_5A_8D_05_03, 8'h00, 16'h0305, 8'hA5);          // EOR
      add_test(128'hA9_40_C9_40_F0_03_8E_06_03_8D_06_03, 8'h00, 16'h0306, 8'h40);     // BEQ
      add_test(128'hA9_41_C5_10_D0_03_8E_06_03_8D_06_03, 8'h40, 16'h0306, 8'h41);     // BNE
      add_test(128'hA9_10_C9_20_30_03_8E_06_03_8D_06_03, 8'h00, 16'h0306, 8'h10);     // BMI
      add_test(128'hA2_77_A9_10_C9_20_B0_03_8E_06_03_8D_06_03, 8'h00, 16'h0306, 8'h77);
      add_test(128'hA9_7F_C9_01_10_03_8E_06_03_8D_06_03, 8'h00, 16'h0306, 8'h7F);     // BPL
      add_test(128'hA9_FF_AA_E8_E8_8A_8D_07_03, 8'h00, 16'h0307, 8'h01);    // INX wraps
      add_test(128'hA0_00_88_88_98_8D_07_03, 8'h00, 16'h0307, 8'hFE);       // DEY wraps
      add_test(128'hA2_80_CA_86_21, 8'h00, 16'h0021, 8'h7F);                // DEX, STX zp
      add_test(128'hA9_5E_4C_08_02_8E_08_03_8D_08_03, 8'h00, 16'h0308, 8'h5E);        // JMP
      add_test(128'hA2_05_C8_CA_D0_FC_8C_09_03, 8'h00, 16'h0309, 8'h05);    // Loop count in Y
      add_test(128'hA2_05_CA_D0_FD_8E_09_03, 8'h00, 16'h0309, 8'h00);       // Loop exit X
      add_test(128'hA9_12_EA_02_8D_0A_03, 8'h00, 16'h030A, 8'h12);          // NOP, bad opcode
      add_test(128'h18_A9_70_69_20_B8_50_03_8E_0A_03_8D_0A_03, 8'h00, 16'h030A, 8'h90);
   endtask

   function automatic logic [7:0] fill_byte(input logic [15:0] a);
      return a[15:8] ^ a[7:0] ^ 8'h5A;
   endfunction

   task automatic load_program(input int idx);
      logic [127:0] code;
      int           len;
      int           i;
      int           a;
      code = code_tab[idx];
      for (a = 0; a < 65536; a++)
         mem_i.mem[a] = fill_byte(a[15:0]);
      len = 0;
      for (i = 0; i < 16; i++)
         if (code[8*i +: 8] != 8'h00)
            len = i + 1;   // Leading byte is an opcode, never zero
      for (i = 0; i < len; i++)
         mem_i.mem[PROG_BASE + i] = code[8*(len-1-i) +: 8];
      mem_i.mem[VECTOR]         = PROG_BASE[7:0];
      mem_i.mem[VECTOR + 16'd1] = PROG_BASE[15:8];
      mem_i.mem[16'h0010]       = zp_tab[idx];
   endtask

   task automatic check_value(input string what, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected)
      begin
         $display("ERROR at %0t: %s expected %h, got %h", $time, what, expected, actual);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic run_test(input int idx);
      reset_n = 1'b0;
      @(posedge clk);
      #1;
      load_program(idx);   // CPU is held in reset, no bus traffic
      repeat (2) @(posedge clk);
      #1 reset_n = 1'b1;
      while (!(rd_req || wr_en))
      begin
         @(posedge clk);
         #1;
      end
      check_value($sformatf("test %0d first request is a read", idx), 16'h0001,
                  {15'h0000, rd_req});
      check_value($sformatf("test %0d first request address", idx), VECTOR, bus_addr);
      while (!written)
      begin
         @(posedge clk);
         #1;
      end
      check_value($sformatf("test %0d write address", idx), addr_tab[idx], wr_addr);
      check_value($sformatf("test %0d write data", idx), {8'h00, value_tab[idx]},
                  {8'h00, wr_value});
   endtask

   initial
   begin
      int pass;
      int idx;
      reset_n  = 1'b0;
      stall_en = 1'b0;
      build_table();
      for (pass = 0; pass < 2; pass++)
      begin
         stall_en = (pass == 1);   // Second round with back-pressure
         for (idx = 0; idx < entries; idx++)
            run_test(idx);
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

   initial
   begin
      repeat (CYCLE_LIMIT) @(posedge clk);
      $display("Timeout after %0d cycles, the CPU never wrote its result", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $fatal(1);
   end

endmodule

`default_nettype wire

// File: project.f
hw/m6502_pkg.sv
hw/m6502_decode.sv
hw/m6502_alu.sv
hw/m6502_regs.sv
hw/m6502_control.sv
hw/m6502_cpu.sv
bench/m6502_mem.sv
bench/m6502_tb.sv
